/* hdl/branch_issue_stage.sv */
`include "mips_id_cfg.svh"

module branch_issue_stage
	import mips_id_pkg::*;
(
	input  logic      clk,
	input  logic      reset_i,
	input  alusel_e   alusel_i,
	input  aluop_e    aluop_i,
	input  reg_addr_t waddr_i,
	input  logic      we_i,
	input  br_cond_e  br_cond_i,
	input  word_t     br_target_i,
	input  word_t     link_addr_i,
	input  word_t     op0_i,
	input  word_t     op1_i,
	input  logic      delay_slot_i,
	output alusel_e   alusel_o,
	output aluop_e    aluop_o,
	output word_t     reg1_o,
	output word_t     reg2_o,
	output reg_addr_t waddr_o,
	output logic      we_o,
	output logic      branch_flag_o,
	output word_t     branch_target_address_o,
	output word_t     link_addr_o,
	output logic      next_inst_in_delayslot_o,
	output logic      is_in_delayslot_o
);

	logic  taken;
	logic  reg_jump;
	logic  sign0;
	logic  zero0;
	word_t target;

	assign sign0    = op0_i[`WORD_W-1];
	assign zero0    = op0_i == '0;
	assign reg_jump = aluop_i == alu_jr || aluop_i == alu_jalr;

	always_comb begin
		case (br_cond_i)
			br_always: taken = 1'b1;
			br_eq:     taken = op0_i == op1_i;
			br_ne:     taken = op0_i != op1_i;
			br_lez:    taken = sign0 || zero0;
			br_gtz:    taken = !sign0 && !zero0;
			br_ltz:    taken = sign0;
			br_gez:    taken = !sign0;
			default:   taken = 1'b0;
		endcase
	end

	// jr/jalr jump to the forwarded rs value
	assign target = !taken ? '0 : (reg_jump ? op0_i : br_target_i);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			alusel_o                 <= res_nop;
			aluop_o                  <= alu_nop;
			reg1_o                   <= '0;
			reg2_o                   <= '0;
			waddr_o                  <= '0;
			we_o                     <= 1'b0;
			branch_flag_o            <= 1'b0;
			branch_target_address_o  <= '0;
			link_addr_o              <= '0;
			next_inst_in_delayslot_o <= 1'b0;
			is_in_delayslot_o        <= 1'b0;
		end else begin
			alusel_o                 <= alusel_i;
			aluop_o                  <= aluop_i;
			reg1_o                   <= op0_i;
			reg2_o                   <= op1_i;
			waddr_o                  <= waddr_i;
			we_o                     <= we_i;
			branch_flag_o            <= taken;
			branch_target_address_o  <= target;
			link_addr_o              <= link_addr_i;
			next_inst_in_delayslot_o <= taken;   // the following word is the slot
			is_in_delayslot_o        <= delay_slot_i;
		end
	end

	a_flag_class: assert property (@(posedge clk) disable iff (reset_i)
		branch_flag_o |-> alusel_o == res_jump_branch)
		else $error("branch taken on a non jump class");

	a_we_class: assert property (@(posedge clk) disable iff (reset_i)
		we_o |-> alusel_o != res_nop)
		else $error("write enable on a nop class");

endmodule

/* hdl/inst_decoder.sv */
`include "mips_id_cfg.svh"

module inst_decoder
	import mips_id_pkg::*;
(
	input  word_t            pc_i,
	input  word_t            inst_i,
	output logic [1:0]       rd_en_o,     // bit 0 rs and bit 1 rt
	output reg_addr_t [1:0]  rd_addr_o,
	output word_t            imm_o,
	output alusel_e          alusel_o,
	output aluop_e           aluop_o,
	output reg_addr_t        waddr_o,
	output logic             we_o,
	output br_cond_e         br_cond_o,
	output word_t            br_target_o,
	output word_t            link_addr_o
);

	localparam logic [5:0] opc_special = 6'h00;
	localparam logic [5:0] opc_regimm  = 6'h01;
	localparam logic [5:0] opc_j       = 6'h02;
	localparam logic [5:0] opc_jal     = 6'h03;
	localparam logic [5:0] opc_beq     = 6'h04;
	localparam logic [5:0] opc_bne     = 6'h05;
	localparam logic [5:0] opc_blez    = 6'h06;
	localparam logic [5:0] opc_bgtz    = 6'h07;
	localparam logic [5:0] opc_addi    = 6'h08;
	localparam logic [5:0] opc_addiu   = 6'h09;
	localparam logic [5:0] opc_slti    = 6'h0a;
	localparam logic [5:0] opc_sltiu   = 6'h0b;
	localparam logic [5:0] opc_andi    = 6'h0c;
	localparam logic [5:0] opc_ori     = 6'h0d;
	localparam logic [5:0] opc_xori    = 6'h0e;
	localparam logic [5:0] opc_lui     = 6'h0f;

	localparam logic [5:0] fn_sllv = 6'h04;
	localparam logic [5:0] fn_srlv = 6'h06;
	localparam logic [5:0] fn_srav = 6'h07;
	localparam logic [5:0] fn_jr   = 6'h08;
	localparam logic [5:0] fn_jalr = 6'h09;
	localparam logic [5:0] fn_add  = 6'h20;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_sub  = 6'h22;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_nor  = 6'h27;
	localparam logic [5:0] fn_slt  = 6'h2a;
	localparam logic [5:0] fn_sltu = 6'h2b;

	localparam logic [4:0] rt_bltz   = 5'h00;
	localparam logic [4:0] rt_bgez   = 5'h01;
	localparam logic [4:0] rt_bltzal = 5'h10;
	localparam logic [4:0] rt_bgezal = 5'h11;

	logic [5:0]  op;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  sa;
	logic [5:0]  funct;
	logic [15:0] imm16;
	word_t       pc_plus_4;
	word_t       pc_plus_8;
	word_t       branch_target;
	word_t       jump_target;
	aluop_e      shift_op;
	reg_addr_t   wr_addr;
	logic        const_shift;

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign funct = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	assign pc_plus_4     = pc_i + `PC_STEP;
	assign pc_plus_8     = pc_plus_4 + `PC_STEP;
	assign branch_target = pc_plus_4 + {{14{imm16[15]}}, imm16, 2'b00};
	assign jump_target   = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

	// sll/srl/sra with rs zero and funct 00, 02 or 03
	assign const_shift = rs == 5'd0 && funct[5:2] == 4'b0000 && funct[1:0] != 2'b01;

	always_comb begin
		case (funct[1:0])
			2'b10:   shift_op = alu_srl;
			2'b11:   shift_op = alu_sra;
			default: shift_op = alu_sll;
		endcase
	end

	always_comb begin
		alusel_o    = res_nop;
		aluop_o     = alu_nop;
		we_o        = 1'b0;
		wr_addr     = rd;
		rd_en_o     = 2'b00;
		imm_o       = '0;
		br_cond_o   = br_none;
		br_target_o = '0;
		link_addr_o = '0;
		case (op)
			opc_special: begin
				if (const_shift) begin
					alusel_o = res_shift;
					aluop_o  = shift_op;
					we_o     = 1'b1;
					rd_en_o  = 2'b10;             // operand 0 carries sa
					imm_o    = {27'd0, sa};
				end else if (sa == 5'd0) begin
					case (funct)
						fn_and, fn_or, fn_xor, fn_nor: alusel_o = res_logic;
						fn_sllv, fn_srlv, fn_srav: alusel_o = res_shift;
						fn_jr, fn_jalr: alusel_o = res_jump_branch;
						fn_add, fn_addu, fn_sub, fn_subu, fn_slt, fn_sltu: alusel_o = res_math;
						default: alusel_o = res_nop;
					endcase
					case (funct)
						fn_and:  aluop_o = alu_and;
						fn_or:   aluop_o = alu_or;
						fn_xor:  aluop_o = alu_xor;
						fn_nor:  aluop_o = alu_nor;
						fn_add:  aluop_o = alu_add;
						fn_addu: aluop_o = alu_addu;
						fn_sub:  aluop_o = alu_sub;
						fn_subu: aluop_o = alu_subu;
						fn_slt:  aluop_o = alu_slt;
						fn_sltu: aluop_o = alu_sltu;
						fn_jr:   aluop_o = alu_jr;
						fn_jalr: aluop_o = alu_jalr;
						fn_sllv, fn_srlv, fn_srav: aluop_o = shift_op;
						default: aluop_o = alu_nop;
					endcase
					if (alusel_o != res_nop) begin
						we_o    = funct != fn_jr;
						rd_en_o = (alusel_o == res_jump_branch) ? 2'b01 : 2'b11;
					end
					if (alusel_o == res_jump_branch) begin
						br_cond_o = br_always;       // target is operand 0 in the issue stage
					end
					if (funct == fn_jalr) begin
						link_addr_o = pc_plus_8;
					end
				end
			end
			opc_regimm: begin
				if (rt == rt_bltz || rt == rt_bgez || rt == rt_bltzal || rt == rt_bgezal) begin
					alusel_o    = res_jump_branch;
					rd_en_o     = 2'b01;
					br_target_o = branch_target;
					br_cond_o   = rt[0] ? br_gez : br_ltz;
					if (rt[4]) begin
						aluop_o     = rt[0] ? alu_bgezal : alu_bltzal;
						we_o        = 1'b1;
						wr_addr     = `RA_REG;
						link_addr_o = pc_plus_8;
					end else begin
						aluop_o = rt[0] ? alu_bgez : alu_bltz;
					end
				end
			end
			opc_j, opc_jal: begin
				alusel_o    = res_jump_branch;
				aluop_o     = op[0] ? alu_jal : alu_j;
				br_cond_o   = br_always;
				br_target_o = jump_target;
				if (op[0]) begin
					we_o        = 1'b1;
					wr_addr     = `RA_REG;
					link_addr_o = pc_plus_8;
				end
			end
			opc_beq, opc_bne, opc_blez, opc_bgtz: begin
				alusel_o    = res_jump_branch;
				br_target_o = branch_target;
				case (op[1:0])
					2'b00: begin
						aluop_o   = alu_beq;
						br_cond_o = br_eq;
					end
					2'b01: begin
						aluop_o   = alu_bne;
						br_cond_o = br_ne;
					end
					2'b10: begin
						aluop_o   = alu_blez;
						br_cond_o = br_lez;
					end
					default: begin
						aluop_o   = alu_bgtz;
						br_cond_o = br_gtz;
					end
				endcase
				rd_en_o = op[1] ? 2'b01 : 2'b11;   // blez/bgtz compare with zero
			end
			opc_addi, opc_addiu, opc_slti, opc_sltiu: begin
				alusel_o = res_math;
				we_o     = 1'b1;
				wr_addr  = rt;
				rd_en_o  = 2'b01;
				imm_o    = {{16{imm16[15]}}, imm16};
				case (op[1:0])
					2'b00:   aluop_o = alu_add;
					2'b01:   aluop_o = alu_addu;
					2'b10:   aluop_o = alu_slt;
					default: aluop_o = alu_sltu;
				endcase
			end
			opc_andi, opc_ori, opc_xori: begin
				alusel_o = res_logic;
				we_o     = 1'b1;
				wr_addr  = rt;
				rd_en_o  = 2'b01;
				imm_o    = {16'd0, imm16};
				case (op[1:0])
					2'b00:   aluop_o = alu_and;
					2'b01:   aluop_o = alu_or;
					default: aluop_o = alu_xor;
				endcase
			end
			opc_lui: begin
				// both operands take the shifted constant
				alusel_o = res_logic;
				aluop_o  = alu_or;
				we_o     = 1'b1;
				wr_addr  = rt;
				imm_o    = {imm16, 16'd0};
			end
			default: begin
			end
		endcase
	end

	assign waddr_o      = we_o ? wr_addr : `NOP_REG;
	assign rd_addr_o[0] = rd_en_o[0] ? rs : `NOP_REG;
	assign rd_addr_o[1] = rd_en_o[1] ? rt : `NOP_REG;

endmodule

/* hdl/mips_id.sv */
`include "mips_id_cfg.svh"

module mips_id
	import mips_id_pkg::*;
(
	input  logic      clk,
	input  logic      reset_i,

	// from IF and the register file
	input  word_t     pc_i,
	input  word_t     inst_i,
	input  word_t     reg1_data_i,
	input  word_t     reg2_data_i,

	// EX and MEM write back, for forwarding
	input  reg_addr_t ex_waddr_i,
	input  logic      ex_we_i,
	input  word_t     ex_wdata_i,
	input  reg_addr_t mem_waddr_i,
	input  logic      mem_we_i,
	input  word_t     mem_wdata_i,
	input  logic      is_in_delayslot_i,

	// register file read port, same cycle
	output logic      reg1_re_o,
	output logic      reg2_re_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o,

	// to EX, registered
	output alusel_e   alusel_o,
	output aluop_e    aluop_o,
	output word_t     reg1_o,
	output word_t     reg2_o,
	output reg_addr_t waddr_o,
	output logic      we_o,
	output logic      next_inst_in_delayslot_o,
	output logic      branch_flag_o,
	output word_t     branch_target_address_o,
	output word_t     link_addr_o,
	output logic      is_in_delayslot_o
);

	logic [1:0]      rd_en;
	reg_addr_t [1:0] rd_addr;
	word_t           imm;
	alusel_e         alusel;
	aluop_e          aluop;
	reg_addr_t       waddr;
	logic            we;
	br_cond_e        br_cond;
	word_t           br_target;
	word_t           link_addr;
	word_t [1:0]     rf_data;
	word_t [1:0]     operand;

	assign rf_data     = {reg2_data_i, reg1_data_i};
	assign reg1_re_o   = rd_en[0];
	assign reg2_re_o   = rd_en[1];
	assign reg1_addr_o = rd_addr[0];
	assign reg2_addr_o = rd_addr[1];

	inst_decoder u_decoder (
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.rd_en_o     (rd_en),
		.rd_addr_o   (rd_addr),
		.imm_o       (imm),
		.alusel_o    (alusel),
		.aluop_o     (aluop),
		.waddr_o     (waddr),
		.we_o        (we),
		.br_cond_o   (br_cond),
		.br_target_o (br_target),
		.link_addr_o (link_addr)
	);

	for (genvar k = 0; k < 2; k++) begin : g_operand
		operand_forward u_forward (
			.rd_en_i     (rd_en[k]),
			.rd_addr_i   (rd_addr[k]),
			.imm_i       (imm),
			.rf_data_i   (rf_data[k]),
			.ex_we_i     (ex_we_i),
			.ex_waddr_i  (ex_waddr_i),
			.ex_wdata_i  (ex_wdata_i),
			.mem_we_i    (mem_we_i),
			.mem_waddr_i (mem_waddr_i),
			.mem_wdata_i (mem_wdata_i),
			.operand_o   (operand[k])
		);
	end

	branch_issue_stage u_issue (
		.clk                      (clk),
		.reset_i                  (reset_i),
		.alusel_i                 (alusel),
		.aluop_i                  (aluop),
		.waddr_i                  (waddr),
		.we_i                     (we),
		.br_cond_i                (br_cond),
		.br_target_i              (br_target),
		.link_addr_i              (link_addr),
		.op0_i                    (operand[0]),
		.op1_i                    (operand[1]),
		.delay_slot_i             (is_in_delayslot_i),
		.alusel_o                 (alusel_o),
		.aluop_o                  (aluop_o),
		.reg1_o                   (reg1_o),
		.reg2_o                   (reg2_o),
		.waddr_o                  (waddr_o),
		.we_o                     (we_o),
		.branch_flag_o            (branch_flag_o),
		.branch_target_address_o  (branch_target_address_o),
		.link_addr_o              (link_addr_o),
		.next_inst_in_delayslot_o (next_inst_in_delayslot_o),
		.is_in_delayslot_o        (is_in_delayslot_o)
	);

endmodule

/* hdl/mips_id_cfg.svh */
`ifndef MIPS_ID_CFG_SVH
`define MIPS_ID_CFG_SVH

// datapath and address width
`define WORD_W 32

// 32 general registers
`define REG_ADDR_W 5

// return address register, written by jal, jalr default and the al branches
`define RA_REG 5'd31

// r0 is read as zero, so it is safe to address when nothing is needed
`define NOP_REG 5'd0

// bytes per instruction word
`define PC_STEP 32'd4

`endif

/* hdl/mips_id_pkg.sv */
`include "mips_id_cfg.svh"

package mips_id_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// result class for EX
	typedef enum logic [2:0] {
		res_nop         = 3'd0,
		res_logic       = 3'd1,
		res_shift       = 3'd2,
		res_math        = 3'd3,
		res_jump_branch = 3'd4
	} alusel_e;

	// subtype, upper nibble follows the class
	typedef enum logic [7:0] {
		alu_nop    = 8'h00,
		alu_and    = 8'h10,
		alu_or     = 8'h11,
		alu_xor    = 8'h12,
		alu_nor    = 8'h13,
		alu_sll    = 8'h20,
		alu_srl    = 8'h21,
		alu_sra    = 8'h22,
		alu_add    = 8'h30,
		alu_addu   = 8'h31,
		alu_sub    = 8'h32,
		alu_subu   = 8'h33,
		alu_slt    = 8'h34,
		alu_sltu   = 8'h35,
		alu_j      = 8'h40,
		alu_jal    = 8'h41,
		alu_jr     = 8'h42,
		alu_jalr   = 8'h43,
		alu_beq    = 8'h44,
		alu_bne    = 8'h45,
		alu_blez   = 8'h46,
		alu_bgtz   = 8'h47,
		alu_bltz   = 8'h48,
		alu_bgez   = 8'h49,
		alu_bltzal = 8'h4a,
		alu_bgezal = 8'h4b
	} aluop_e;

	// condition tested on the forwarded operands
	typedef enum logic [2:0] {
		br_none   = 3'd0,
		br_always = 3'd1,
		br_eq     = 3'd2,
		br_ne     = 3'd3,
		br_lez    = 3'd4,
		br_gtz    = 3'd5,
		br_ltz    = 3'd6,
		br_gez    = 3'd7
	} br_cond_e;

endpackage

/* hdl/operand_forward.sv */
`include "mips_id_cfg.svh"

module operand_forward
	import mips_id_pkg::*;
(
	input  logic      rd_en_i,
	input  reg_addr_t rd_addr_i,
	input  word_t     imm_i,
	input  word_t     rf_data_i,
	input  logic      ex_we_i,
	input  reg_addr_t ex_waddr_i,
	input  word_t     ex_wdata_i,
	input  logic      mem_we_i,
	input  reg_addr_t mem_waddr_i,
	input  word_t     mem_wdata_i,
	output word_t     operand_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_we_i && ex_waddr_i == rd_addr_i;
	assign mem_hit = mem_we_i && mem_waddr_i == rd_addr_i;

	always_comb begin
		if (!rd_en_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_wdata_i;      // youngest result first
		end else if (mem_hit) begin
			operand_o = mem_wdata_i;
		end else begin
			operand_o = rf_data_i;
		end
	end

endmodule

/* mips_id.f */
+incdir+hdl
hdl/mips_id_pkg.sv
hdl/inst_decoder.sv
hdl/operand_forward.sv
hdl/branch_issue_stage.sv
hdl/mips_id.sv
test/tb_mips_id.sv

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with verilator, run it, judge by the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_mips_id -f mips_id.f

./obj_dir/Vtb_mips_id > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
exit 1

/* test/tb_mips_id.sv */
`include "mips_id_cfg.svh"

module tb_mips_id
	import mips_id_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	localparam int reset_cycles = 16;
	localparam int test_cycles  = 2000;
	localparam int cycle_limit  = reset_cycles + test_cycles + 50;
	localparam int n_patterns   = 44;
	localparam logic [31:0] lfsr_seed = 32'hd4445f5a;

	// fixed fields per instruction format with the rest random
	localparam logic [31:0] m_csh = 32'hffe0_003f;  // op, rs, funct
	localparam logic [31:0] m_r   = 32'hfc00_07ff;  // op, sa, funct
	localparam logic [31:0] m_op  = 32'hfc00_0000;
	localparam logic [31:0] m_ri  = 32'hfc1f_0000;  // op, rt

	typedef struct packed {
		logic      re1;
		logic      re2;
		reg_addr_t addr1;
		reg_addr_t addr2;
		alusel_e   alusel;
		aluop_e    aluop;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t waddr;
		logic      we;
		logic      flag;
		word_t     target;
		word_t     link;
		logic      next_ds;
		logic      ds;
	} expect_t;

	logic      clk = 1'b0;
	logic      reset_i;
	word_t     pc_i, inst_i, reg1_data_i, reg2_data_i;
	reg_addr_t ex_waddr_i, mem_waddr_i;
	logic      ex_we_i, mem_we_i, is_in_delayslot_i;
	word_t     ex_wdata_i, mem_wdata_i;
	logic      reg1_re_o, reg2_re_o;
	reg_addr_t reg1_addr_o, reg2_addr_o;
	alusel_e   alusel_o;
	aluop_e    aluop_o;
	word_t     reg1_o, reg2_o;
	reg_addr_t waddr_o;
	logic      we_o, next_inst_in_delayslot_o, branch_flag_o, is_in_delayslot_o;
	word_t     branch_target_address_o, link_addr_o;

	logic [31:0] lfsr;
	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	expect_t     cur_exp;
	expect_t     pending;
	logic        pending_valid = 1'b0;

	mips_id DUT (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		int          i;
		bits = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[30:0], lfsr[0]};
		end
		return bits;
	endfunction

	// a quarter of the words are zero for blez and bgtz
	function automatic word_t draw_data();
		logic [31:0] mode;
		mode = take_bits(2);
		if (mode == 0) begin
			return '0;
		end
		return take_bits(32);
	endfunction

	// bias write-back addresses towards the fields being read
	function automatic reg_addr_t pick_addr(input word_t word);
		logic [31:0] mode;
		mode = take_bits(2);
		case (mode)
			0:       return word[25:21];
			1:       return word[20:16];
			default: return 5'(take_bits(5));
		endcase
	endfunction

	// {mask, value}
	function automatic logic [63:0] inst_pattern(input int kind);
		case (kind)
			0:       return {m_csh, 32'h0000_0000};  // sll
			1:       return {m_csh, 32'h0000_0002};
			2:       return {m_csh, 32'h0000_0003};
			3:       return {m_r, 32'h0000_0004};    // sllv
			4:       return {m_r, 32'h0000_0006};
			5:       return {m_r, 32'h0000_0007};
			6:       return {m_r, 32'h0000_0024};    // and
			7:       return {m_r, 32'h0000_0025};
			8:       return {m_r, 32'h0000_0026};
			9:       return {m_r, 32'h0000_0027};
			10:      return {m_r, 32'h0000_0020};    // add
			11:      return {m_r, 32'h0000_0021};
			12:      return {m_r, 32'h0000_0022};
			13:      return {m_r, 32'h0000_0023};
			14:      return {m_r, 32'h0000_002a};
			15:      return {m_r, 32'h0000_002b};
			16:      return {m_r, 32'h0000_0008};    // jr
			17:      return {m_r, 32'h0000_0009};
			18:      return {m_op, 32'h2000_0000};   // addi
			19:      return {m_op, 32'h2400_0000};
			20:      return {m_op, 32'h2800_0000};
			21:      return {m_op, 32'h2c00_0000};
			22:      return {m_op, 32'h3000_0000};   // andi
			23:      return {m_op, 32'h3400_0000};
			24:      return {m_op, 32'h3800_0000};
			25:      return {m_op, 32'h3c00_0000};   // lui
			26:      return {m_op, 32'h0800_0000};   // j
			27:      return {m_op, 32'h0c00_0000};
			28:      return {m_op, 32'h1000_0000};   // beq
			29:      return {m_op, 32'h1400_0000};
			30:      return {m_op, 32'h1800_0000};
			31:      return {m_op, 32'h1c00_0000};
			32:      return {m_ri, 32'h0400_0000};   // bltz
			33:      return {m_ri, 32'h0401_0000};
			34:      return {m_ri, 32'h0410_0000};
			35:      return {m_ri, 32'h0411_0000};
			36:      return {m_r, 32'h0000_0010};    // mfhi is dropped
			37:      return {m_r, 32'h0000_0018};    // mult
			38:      return {m_r, 32'h0000_001b};    // divu
			39:      return {m_r, 32'h0000_000a};    // movz
			40:      return {m_op, 32'h7000_0000};   // special2
			41:      return {m_op, 32'hcc00_0000};   // pref
			42:      return {m_op, 32'h8c00_0000};   // lw is not decoded here
			default: return {32'h0000_0000, 32'h0000_0000};
		endcase
	endfunction

	function automatic alusel_e class_of(input aluop_e op);
		if (op inside {alu_and, alu_or, alu_xor, alu_nor}) return res_logic;
		if (op inside {alu_sll, alu_srl, alu_sra}) return res_shift;
		if (op inside {alu_add, alu_addu, alu_sub, alu_subu, alu_slt, alu_sltu}) return res_math;
		if (op == alu_nop) return res_nop;
		return res_jump_branch;
	endfunction

	function automatic word_t forwarded_value(input logic en, input reg_addr_t addr,
		input word_t imm, input word_t rf);
		if (!en) return imm;
		if (ex_we_i && ex_waddr_i == addr) return ex_wdata_i;
		if (mem_we_i && mem_waddr_i == addr) return mem_wdata_i;
		return rf;
	endfunction

	function automatic expect_t reference_decode(input word_t pc, input word_t inst,
		input word_t rf1, input word_t rf2, input logic ds);
		expect_t    e;
		logic [5:0] op;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] sa;
		word_t      sx;
		word_t      imm;
		word_t      pc4;
		reg_addr_t  dest;
		logic       taken;
		op   = inst[31:26];
		rs   = inst[25:21];
		rt   = inst[20:16];
		rd   = inst[15:11];
		sa   = inst[10:6];
		fn   = inst[5:0];
		sx   = {{16{inst[15]}}, inst[15:0]};
		pc4  = pc + `PC_STEP;
		e    = '0;
		imm  = '0;
		dest = rd;
		case (op)
			6'h00: begin
				if (rs == 5'd0 && fn inside {6'h00, 6'h02, 6'h03}) begin
					case (fn)
						6'h00:   e.aluop = alu_sll;
						6'h02:   e.aluop = alu_srl;
						default: e.aluop = alu_sra;
					endcase
					e.re2 = 1'b1;
					imm   = {27'd0, sa};  // shift amount on operand 0
				end else if (sa == 5'd0) begin
					case (fn)
						6'h04:   e.aluop = alu_sll;
						6'h06:   e.aluop = alu_srl;
						6'h07:   e.aluop = alu_sra;
						6'h08:   e.aluop = alu_jr;
						6'h09:   e.aluop = alu_jalr;
						6'h20:   e.aluop = alu_add;
						6'h21:   e.aluop = alu_addu;
						6'h22:   e.aluop = alu_sub;
						6'h23:   e.aluop = alu_subu;
						6'h24:   e.aluop = alu_and;
						6'h25:   e.aluop = alu_or;
						6'h26:   e.aluop = alu_xor;
						6'h27:   e.aluop = alu_nor;
						6'h2a:   e.aluop = alu_slt;
						6'h2b:   e.aluop = alu_sltu;
						default: e.aluop = alu_nop;
					endcase
					e.re1 = e.aluop != alu_nop;
					e.re2 = !(e.aluop inside {alu_nop, alu_jr, alu_jalr});
				end
			end
			6'h01: begin
				case (rt)
					5'h00:   e.aluop = alu_bltz;
					5'h01:   e.aluop = alu_bgez;
					5'h10:   e.aluop = alu_bltzal;
					5'h11:   e.aluop = alu_bgezal;
					default: e.aluop = alu_nop;
				endcase
				e.re1 = e.aluop != alu_nop;
			end
			6'h02: e.aluop = alu_j;
			6'h03: e.aluop = alu_jal;
			6'h04, 6'h05: begin
				e.aluop = op[0] ? alu_bne : alu_beq;
				e.re1   = 1'b1;
				e.re2   = 1'b1;
			end
			6'h06, 6'h07: begin
				e.aluop = op[0] ? alu_bgtz : alu_blez;
				e.re1   = 1'b1;
			end
			6'h08, 6'h09, 6'h0a, 6'h0b: begin
				case (op[1:0])
					2'b00:   e.aluop = alu_add;
					2'b01:   e.aluop = alu_addu;
					2'b10:   e.aluop = alu_slt;
					default: e.aluop = alu_sltu;
				endcase
				e.re1 = 1'b1;
				imm   = sx;
				dest  = rt;
			end
			6'h0c, 6'h0d, 6'h0e: begin
				case (op[1:0])
					2'b00:   e.aluop = alu_and;
					2'b01:   e.aluop = alu_or;
					default: e.aluop = alu_xor;
				endcase
				e.re1 = 1'b1;
				imm   = {16'd0, inst[15:0]};
				dest  = rt;
			end
			6'h0f: begin
				e.aluop = alu_or;  // lui reads nothing
				imm     = {inst[15:0], 16'd0};
				dest    = rt;
			end
			default: e.aluop = alu_nop;
		endcase

		e.alusel = class_of(e.aluop);
		e.we = !(e.aluop inside {alu_nop, alu_j, alu_jr, alu_beq, alu_bne,
			alu_blez, alu_bgtz, alu_bltz, alu_bgez});
		if (e.aluop inside {alu_jal, alu_bltzal, alu_bgezal}) dest = `RA_REG;
		e.waddr = e.we ? dest : 5'd0;
		e.addr1 = e.re1 ? rs : 5'd0;
		e.addr2 = e.re2 ? rt : 5'd0;
		e.reg1  = forwarded_value(e.re1, e.addr1, imm, rf1);
		e.reg2  = forwarded_value(e.re2, e.addr2, imm, rf2);

		case (e.aluop)
			alu_j, alu_jal, alu_jr, alu_jalr: taken = 1'b1;
			alu_beq:              taken = e.reg1 == e.reg2;
			alu_bne:              taken = e.reg1 != e.reg2;
			alu_blez:             taken = $signed(e.reg1) <= 0;
			alu_bgtz:             taken = $signed(e.reg1) > 0;
			alu_bltz, alu_bltzal: taken = $signed(e.reg1) < 0;
			alu_bgez, alu_bgezal: taken = $signed(e.reg1) >= 0;
			default:              taken = 1'b0;
		endcase
		e.flag    = taken;
		e.next_ds = taken;
		if (!taken) begin
			e.target = '0;
		end else if (e.aluop inside {alu_jr, alu_jalr}) begin
			e.target = e.reg1;
		end else if (e.aluop inside {alu_j, alu_jal}) begin
			e.target = {pc4[31:28], inst[25:0], 2'b00};
		end else begin
			e.target = pc4 + {sx[29:0], 2'b00};
		end
		if (e.aluop inside {alu_jal, alu_jalr, alu_bltzal, alu_bgezal}) e.link = pc4 + `PC_STEP;
		e.ds = ds;
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic compare_registered(input expect_t e);
		check_value("alusel_o", 32'(alusel_o), 32'(e.alusel));
		check_value("aluop_o", 32'(aluop_o), 32'(e.aluop));
		check_value("reg1_o", reg1_o, e.reg1);
		check_value("reg2_o", reg2_o, e.reg2);
		check_value("waddr_o", 32'(waddr_o), 32'(e.waddr));
		check_value("we_o", 32'(we_o), 32'(e.we));
		check_value("branch_flag_o", 32'(branch_flag_o), 32'(e.flag));
		check_value("branch_target_address_o", branch_target_address_o, e.target);
		check_value("link_addr_o", link_addr_o, e.link);
		check_value("next_inst_in_delayslot_o", 32'(next_inst_in_delayslot_o), 32'(e.next_ds));
		check_value("is_in_delayslot_o", 32'(is_in_delayslot_o), 32'(e.ds));
	endtask

	task automatic drive_random();
		int          kind;
		logic [63:0] pat;
		word_t       word;
		word_t       d1;
		logic [29:0] pc_word;
		kind    = take_bits(6) % n_patterns;
		pat     = inst_pattern(kind);
		word    = (take_bits(32) & ~pat[63:32]) | pat[31:0];
		pc_word = 30'(take_bits(30));
		d1      = draw_data();
		inst_i            <= word;
		pc_i              <= {pc_word, 2'b00};
		reg1_data_i       <= d1;
		reg2_data_i       <= (take_bits(2) == 0) ? d1 : draw_data();  // beq/bne hits
		ex_we_i           <= 1'(take_bits(1));
		ex_waddr_i        <= pick_addr(word);
		ex_wdata_i        <= draw_data();
		mem_we_i          <= 1'(take_bits(1));
		mem_waddr_i       <= pick_addr(word);
		mem_wdata_i       <= draw_data();
		is_in_delayslot_i <= 1'(take_bits(1));
	endtask

	initial begin : stimulus
		int n;
		lfsr = lfsr_seed;
		reset_i           <= 1'b1;
		pc_i              <= '0;
		inst_i            <= '0;
		reg1_data_i       <= '0;
		reg2_data_i       <= '0;
		ex_we_i           <= 1'b0;
		ex_waddr_i        <= '0;
		ex_wdata_i        <= '0;
		mem_we_i          <= 1'b0;
		mem_waddr_i       <= '0;
		mem_wdata_i       <= '0;
		is_in_delayslot_i <= 1'b0;
		repeat (reset_cycles) @(posedge clk);
		reset_i <= 1'b0;
		drive_random();
		for (n = 1; n < test_cycles; n++) begin
			@(posedge clk);
			drive_random();
		end
		@(posedge clk);  // last word reaches the output register
		@(negedge clk);
		#10;
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// outputs and inputs are both settled at the falling edge
	always @(negedge clk) begin
		if (pending_valid) begin
			compare_registered(pending);
		end
		cur_exp = reference_decode(pc_i, inst_i, reg1_data_i, reg2_data_i, is_in_delayslot_i);
		check_value("reg1_re_o", 32'(reg1_re_o), 32'(cur_exp.re1));
		check_value("reg2_re_o", 32'(reg2_re_o), 32'(cur_exp.re2));
		check_value("reg1_addr_o", 32'(reg1_addr_o), 32'(cur_exp.addr1));
		check_value("reg2_addr_o", 32'(reg2_addr_o), 32'(cur_exp.addr2));
		if (reset_i) begin
			pending = '0;
		end else begin
			pending = cur_exp;
		end
		pending_valid = 1'b1;
	end

	initial begin : watchdog
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Regression failed");
		$finish;
	end

endmodule
